// ==== hm_testdata.txt ====
// columns: addr rw id hit way(one-hot) evict evict_tag unlock_hold (all hex)
// unlock_hold 0 means a short random unlock delay, else cycles withheld
// set 1, fill both ways then round-robin evictions
1010 0 1 0 1 0 00 00
1014 1 2 1 1 0 00 00
2010 1 3 0 2 0 00 00
3010 0 4 0 1 1 10 00
4010 0 5 0 2 1 20 00
5010 0 6 0 1 0 00 00
4018 0 7 1 2 0 00 00
// set 2, dirty line with a withheld unlock, then a hit that must wait
0520 1 8 0 1 0 00 1e
0524 0 9 1 1 0 00 00
0630 0 a 0 1 0 00 00
0720 0 b 0 2 0 00 00
0820 1 c 0 1 1 05 00
0920 0 d 0 2 0 00 00
0828 0 e 1 1 0 00 00
// set f, the lock on way 0 does not hold back way 1
a0f0 1 f 0 1 0 00 00
a0f4 0 0 1 1 0 00 14
b0f0 0 1 0 2 0 00 00
c0f0 0 2 0 1 1 a0 00
// back to set 1
1010 0 3 0 2 0 00 00
5014 1 4 1 1 0 00 00

// ==== list.f ====
hm_cfg_pkg.sv
hm_types_pkg.sv
hm_lookup_if.sv
hm_lock_if.sv
hm_init_counter.sv
hm_tag_store.sv
hm_lock_table.sv
hm_ctrl.sv
hm_top.sv
hm_tb.sv

// ==== Makefile ====
# Verilator build and run of the hit/miss stage testbench
VERILATOR ?= verilator
TOP       ?= hm_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Verification passed
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log is searched for the pass line, a missing line fails the target
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hm_tb.sv ====
// testbench for the hit/miss stage
// requests and expected results come from hm_testdata.txt with 8 hex words per line
// a behavioral tag store model cross-checks every expected line of the file
// outputs are sampled on the falling edge and inputs change on the rising edge
// the lock model follows the unlocks this bench issues itself
`timescale 1ns/100ps

module hm_tb;
  import hm_cfg_pkg::*;
  import hm_types_pkg::*;

  localparam int unsigned Sets   = 2 ** IndexWidth;
  // words per request line in the data file
  localparam int unsigned Cols   = 8;
  localparam int unsigned MaxReq = 64;

  logic      clk_i;
  logic      rst_i;
  logic      req_valid_i;
  logic      req_ready_o;
  req_desc_t req_desc_i;
  logic      hit_valid_o;
  logic      hit_ready_i;
  logic      miss_valid_o;
  logic      miss_ready_i;
  out_desc_t out_desc_o;
  logic      unlock_valid_i;
  index_t    unlock_index_i;
  way_ind_t  unlock_way_i;

  // data file image and run bookkeeping
  logic [31:0] tdata [Cols*MaxReq];
  int          num_req;
  int          cycle_cnt   = 0;
  int          cycle_limit = 200;
  int          err_cnt     = 0;
  int          file_err_cnt = 0;

  // reference model of tag store and lock bitmap
  tag_t     m_tag   [Sets][Ways];
  way_ind_t m_valid [Sets];
  way_ind_t m_dirty [Sets];
  int       m_ptr   [Sets];
  way_ind_t m_lock  [Sets];

  // unlocks waiting for their due cycle
  int       due_q  [$];
  index_t   uidx_q [$];
  way_ind_t uway_q [$];

  hm_top #(
    .IndexWidth ( IndexWidth ),
    .Ways       ( Ways       ),
    .TagWidth   ( TagWidth   )
  ) hm_top_inst (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .req_valid_i    ( req_valid_i    ),
    .req_ready_o    ( req_ready_o    ),
    .req_desc_i     ( req_desc_i     ),
    .hit_valid_o    ( hit_valid_o    ),
    .hit_ready_i    ( hit_ready_i    ),
    .miss_valid_o   ( miss_valid_o   ),
    .miss_ready_i   ( miss_ready_i   ),
    .out_desc_o     ( out_desc_o     ),
    .unlock_valid_i ( unlock_valid_i ),
    .unlock_index_i ( unlock_index_i ),
    .unlock_way_i   ( unlock_way_i   )
  );

  // 10 ns clock
  always #5 clk_i = ~clk_i;

  // run limit scaled from the request count once the file is read
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
      $display("Errors: %0d value mismatches, %0d data file mismatches",
               err_cnt, file_err_cnt);
      $display("Verification failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // data file access
  ////////////////////////////////////////////////////////////////////////////
  function automatic req_desc_t file_req(input int n);
    req_desc_t r;
    r.addr = tdata[Cols*n][AddrWidth-1:0];
    r.rw   = tdata[Cols*n + 1][0];
    r.id   = tdata[Cols*n + 2][IdWidth-1:0];
    return r;
  endfunction

  // expected descriptor with refill as the inverse of the hit flag in column 3
  function automatic out_desc_t file_result(input int n);
    out_desc_t d;
    d.req       = file_req(n);
    d.refill    = ~tdata[Cols*n + 3][0];
    d.way_ind   = tdata[Cols*n + 4][Ways-1:0];
    d.evict     = tdata[Cols*n + 5][0];
    d.evict_tag = tdata[Cols*n + 6][TagWidth-1:0];
    return d;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // tag store model
  ////////////////////////////////////////////////////////////////////////////
  task automatic model_access(input req_desc_t r, output out_desc_t d);
    index_t idx;
    tag_t   tg;
    int     hit_w;
    int     vic;
    int     w;
    idx   = r.addr[IndexBase +: IndexWidth];
    tg    = r.addr[TagBase +: TagWidth];
    hit_w = -1;
    vic   = -1;
    for (w = 0; w < Ways; w++) begin
      if (m_valid[idx][w] && m_tag[idx][w] == tg) begin
        hit_w = w;
      end
      // first free way from the bottom
      if (vic < 0 && !m_valid[idx][w]) begin
        vic = w;
      end
    end
    d.req       = r;
    d.way_ind   = '0;
    d.evict     = 1'b0;
    d.evict_tag = '0;
    if (hit_w >= 0) begin
      d.refill         = 1'b0;
      d.way_ind[hit_w] = 1'b1;
      if (r.rw) begin
        m_dirty[idx][hit_w] = 1'b1;
      end
    end else begin
      // a full set takes the round-robin way and moves the pointer on
      if (vic < 0) begin
        vic        = m_ptr[idx];
        m_ptr[idx] = (m_ptr[idx] + 1) % Ways;
      end
      d.refill       = 1'b1;
      d.way_ind[vic] = 1'b1;
      d.evict        = m_valid[idx][vic] & m_dirty[idx][vic];
      if (d.evict) begin
        d.evict_tag = m_tag[idx][vic];
      end
      m_tag[idx][vic]   = tg;
      m_valid[idx][vic] = 1'b1;
      m_dirty[idx][vic] = r.rw;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_desc(input out_desc_t got, input out_desc_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("Error %0d ns: out_desc_o is %h, expected %h (id %h)",
               $time, got, exp, exp.req.id);
    end
  endtask

  task automatic check_route(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      err_cnt++;
      $display("Error %0d ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_ready(input logic got, input logic exp);
    if (got !== exp) begin
      err_cnt++;
      $display("Error %0d ns: req_ready_o is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_file_line(input int n, input out_desc_t exp, input out_desc_t mdl);
    if (exp !== mdl) begin
      file_err_cnt++;
      $display("Error %0d ns: request %0d of the data file expects %h, model gives %h",
               $time, n, exp, mdl);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and checking
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    int        i;
    int        k;
    int        pick;
    int        req_ptr;
    int        out_cnt;
    int        cur_req;
    int        hold;
    logic      inflight;
    logic      show;
    logic      out_fire;
    logic      in_fire;
    logic      exp_ready;
    logic      unl_now;
    index_t    unl_idx;
    way_ind_t  unl_way;
    index_t    exp_index;
    out_desc_t exp_desc;
    out_desc_t model_desc;

    clk_i          = 1'b0;
    rst_i          = 1'b1;
    req_valid_i    = 1'b0;
    req_desc_i     = '0;
    hit_ready_i    = 1'b0;
    miss_ready_i   = 1'b0;
    unlock_valid_i = 1'b0;
    unlock_index_i = '0;
    unlock_way_i   = '0;
    void'($urandom(8));

    // all ones marks the end of the file contents
    for (i = 0; i < Cols*MaxReq; i++) begin
      tdata[i] = '1;
    end
    $readmemh("hm_testdata.txt", tdata);
    num_req = 0;
    while (num_req < MaxReq && tdata[Cols*num_req] !== '1) begin
      num_req++;
    end
    if (num_req == 0) begin
      file_err_cnt++;
      $display("No requests could be read from hm_testdata.txt");
    end
    cycle_limit = 40 * num_req + 200;

    // store starts empty after the init sweep
    for (i = 0; i < Sets; i++) begin
      m_valid[i] = '0;
      m_dirty[i] = '0;
      m_ptr[i]   = 0;
      m_lock[i]  = '0;
    end
    req_ptr   = 0;
    out_cnt   = 0;
    cur_req   = 0;
    inflight  = 1'b0;
    in_fire   = 1'b0;
    out_fire  = 1'b0;
    unl_now   = 1'b0;
    unl_idx   = '0;
    unl_way   = '0;
    exp_index = '0;
    exp_desc  = '0;

    // reset over 8 rising edges with quiet outputs
    @(posedge clk_i);
    repeat (7) begin
      @(negedge clk_i);
      check_ready(req_ready_o, 1'b0);
      check_route(hit_valid_o, 1'b0, "hit_valid_o");
      check_route(miss_valid_o, 1'b0, "miss_valid_o");
      @(posedge clk_i);
    end
    rst_i <= 1'b0;

    // init sweep takes one cycle per index without ready
    repeat (Sets) begin
      @(negedge clk_i);
      check_ready(req_ready_o, 1'b0);
      check_route(hit_valid_o, 1'b0, "hit_valid_o");
      check_route(miss_valid_o, 1'b0, "miss_valid_o");
      @(posedge clk_i);
    end

    while (out_cnt < num_req || due_q.size() != 0 || unl_now) begin
      // request is held steady until accepted
      if (!req_valid_i || in_fire) begin
        if (req_ptr < num_req && ($urandom % 4) != 0) begin
          req_valid_i <= 1'b1;
          req_desc_i  <= file_req(req_ptr);
        end else begin
          req_valid_i <= 1'b0;
        end
      end
      hit_ready_i  <= ($urandom % 4) != 0;
      miss_ready_i <= ($urandom % 4) != 0;
      // at most one unlock per cycle and the first due one goes
      unl_now = 1'b0;
      pick    = 0;
      for (k = 0; k < due_q.size(); k++) begin
        if (!unl_now && due_q[k] <= cycle_cnt) begin
          unl_now = 1'b1;
          unl_idx = uidx_q[k];
          unl_way = uway_q[k];
          pick    = k;
        end
      end
      if (unl_now) begin
        due_q.delete(pick);
        uidx_q.delete(pick);
        uway_q.delete(pick);
      end
      unlock_valid_i <= unl_now;
      unlock_index_i <= unl_idx;
      unlock_way_i   <= unl_way;

      @(negedge clk_i);
      // held descriptor shows only while its line is free
      show = inflight && ((m_lock[exp_index] & exp_desc.way_ind) == '0);
      check_route(hit_valid_o, show && !exp_desc.refill, "hit_valid_o");
      check_route(miss_valid_o, show && exp_desc.refill, "miss_valid_o");
      if (show) begin
        check_desc(out_desc_o, exp_desc);
      end
      out_fire  = show && (exp_desc.refill ? miss_ready_i : hit_ready_i);
      exp_ready = !inflight || out_fire;
      check_ready(req_ready_o, exp_ready);
      in_fire   = req_valid_i && exp_ready;

      @(posedge clk_i);
      // model state after this edge where a set wins over an unlock
      if (unl_now) begin
        m_lock[unl_idx] = m_lock[unl_idx] & ~unl_way;
      end
      if (out_fire) begin
        m_lock[exp_index] = m_lock[exp_index] | exp_desc.way_ind;
        hold = tdata[Cols*cur_req + 7];
        if (hold == 0) begin
          hold = int'($urandom % 4);
        end
        due_q.push_back(cycle_cnt + hold);
        uidx_q.push_back(exp_index);
        uway_q.push_back(exp_desc.way_ind);
        out_cnt++;
        inflight = 1'b0;
      end
      if (in_fire) begin
        exp_desc = file_result(req_ptr);
        model_access(req_desc_i, model_desc);
        check_file_line(req_ptr, exp_desc, model_desc);
        exp_index = req_desc_i.addr[IndexBase +: IndexWidth];
        cur_req   = req_ptr;
        inflight  = 1'b1;
        req_ptr++;
      end
    end

    // nothing left on the outputs once drained
    @(negedge clk_i);
    check_route(hit_valid_o, 1'b0, "hit_valid_o");
    check_route(miss_valid_o, 1'b0, "miss_valid_o");
    check_ready(req_ready_o, 1'b1);

    $display("Errors: %0d value mismatches, %0d data file mismatches",
             err_cnt, file_err_cnt);
    if (err_cnt == 0 && file_err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== hm_top.sv ====
// hit/miss stage of a last-level cache
// no request is accepted for 2^IndexWidth cycles after reset
// unlock_way_i is one-hot, unlock has no grant and takes effect next cycle
// geometry parameters must match the hm_cfg_pkg defaults used by the types
`timescale 1ns/100ps

module hm_top #(
  parameter int unsigned IndexWidth = hm_cfg_pkg::IndexWidth,
  parameter int unsigned Ways       = hm_cfg_pkg::Ways,
  parameter int unsigned TagWidth   = hm_cfg_pkg::TagWidth
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // request descriptor in
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  hm_types_pkg::req_desc_t req_desc_i,
  // hit and miss outputs share one descriptor
  output logic                    hit_valid_o,
  input  logic                    hit_ready_i,
  output logic                    miss_valid_o,
  input  logic                    miss_ready_i,
  output hm_types_pkg::out_desc_t out_desc_o,
  // line release from downstream
  input  logic                    unlock_valid_i,
  input  logic [IndexWidth-1:0]   unlock_index_i,
  input  logic [Ways-1:0]         unlock_way_i
);
  import hm_types_pkg::*;

  logic   clear_valid;
  index_t clear_index;
  logic   init_done;

  hm_lookup_if #(
    .IndexWidth ( IndexWidth ),
    .Ways       ( Ways       ),
    .TagWidth   ( TagWidth   )
  ) lookup_if ();

  hm_lock_if #(
    .IndexWidth ( IndexWidth ),
    .Ways       ( Ways       )
  ) lock_if ();

  hm_init_counter init_counter_inst (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .clear_valid_o ( clear_valid ),
    .clear_index_o ( clear_index ),
    .done_o        ( init_done   )
  );

  hm_tag_store #(
    .IndexWidth ( IndexWidth ),
    .Ways       ( Ways       ),
    .TagWidth   ( TagWidth   )
  ) tag_store_inst (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .clear_valid_i ( clear_valid ),
    .clear_index_i ( clear_index ),
    .lookup        ( lookup_if   )
  );

  hm_lock_table #(
    .IndexWidth ( IndexWidth ),
    .Ways       ( Ways       )
  ) lock_table_inst (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .lock           ( lock_if        ),
    .unlock_valid_i ( unlock_valid_i ),
    .unlock_index_i ( unlock_index_i ),
    .unlock_way_i   ( unlock_way_i   )
  );

  hm_ctrl ctrl_inst (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .init_done_i  ( init_done    ),
    .req_valid_i  ( req_valid_i  ),
    .req_ready_o  ( req_ready_o  ),
    .req_desc_i   ( req_desc_i   ),
    .hit_valid_o  ( hit_valid_o  ),
    .hit_ready_i  ( hit_ready_i  ),
    .miss_valid_o ( miss_valid_o ),
    .miss_ready_i ( miss_ready_i ),
    .out_desc_o   ( out_desc_o   ),
    .lookup       ( lookup_if    ),
    .lock         ( lock_if      )
  );

endmodule

// ==== hm_ctrl.sv ====
// accepts one descriptor at a time and routes it to the hit or miss output
// the tag store lookup is issued in the accept cycle
// a descriptor on a locked line waits until the line is unlocked
// output transfer and next accept may share a cycle
`timescale 1ns/100ps

module hm_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    init_done_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  hm_types_pkg::req_desc_t req_desc_i,
  output logic                    hit_valid_o,
  input  logic                    hit_ready_i,
  output logic                    miss_valid_o,
  input  logic                    miss_ready_i,
  output hm_types_pkg::out_desc_t out_desc_o,
  hm_lookup_if.ctrl               lookup,
  hm_lock_if.ctrl                 lock
);
  import hm_cfg_pkg::*;
  import hm_types_pkg::*;

  typedef enum logic [1:0] {
    INIT,
    IDLE,
    BUSY
  } state_e;

  state_e    state_q;
  state_e    state_d;
  req_desc_t desc_q;
  logic      load_desc;
  // a new descriptor may enter this cycle
  logic      can_take;

  // lookup request straight from the input descriptor
  assign lookup.req_index = req_desc_i.addr[IndexBase +: IndexWidth];
  assign lookup.req_tag   = req_desc_i.addr[TagBase +: TagWidth];
  assign lookup.req_dirty = req_desc_i.rw;

  // lock query for the held line
  assign lock.lock_index = desc_q.addr[IndexBase +: IndexWidth];
  assign lock.lock_way   = lookup.res_way;

  ////////////////////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    state_d          = state_q;
    load_desc        = 1'b0;
    can_take         = 1'b0;
    req_ready_o      = 1'b0;
    hit_valid_o      = 1'b0;
    miss_valid_o     = 1'b0;
    lookup.req_valid = 1'b0;
    lookup.res_ack   = 1'b0;
    lock.lock_set    = 1'b0;

    // held descriptor merged with the held result
    out_desc_o.req       = desc_q;
    out_desc_o.way_ind   = lookup.res_way;
    out_desc_o.refill    = ~lookup.res_hit;
    out_desc_o.evict     = lookup.res_evict;
    out_desc_o.evict_tag = lookup.res_evict_tag;

    unique case (state_q)
      // wait for the tag store sweep
      INIT: begin
        if (init_done_i) begin
          state_d = IDLE;
        end
      end
      IDLE: begin
        can_take = 1'b1;
      end
      BUSY: begin
        // nothing is presented while the line is in use downstream
        if (lookup.res_valid && !lock.locked) begin
          hit_valid_o  = lookup.res_hit;
          miss_valid_o = ~lookup.res_hit;
          if ((hit_valid_o && hit_ready_i) || (miss_valid_o && miss_ready_i)) begin
            lock.lock_set  = 1'b1;
            lookup.res_ack = 1'b1;
            can_take       = 1'b1;
            state_d        = IDLE;
          end
        end
      end
      default: begin
        state_d = INIT;
      end
    endcase

    // accept path, shared by IDLE and the hand-off cycle of BUSY
    if (can_take) begin
      lookup.req_valid = req_valid_i;
      req_ready_o      = lookup.req_ready;
      if (req_valid_i && lookup.req_ready) begin
        load_desc = 1'b1;
        state_d   = BUSY;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= INIT;
    end else begin
      state_q <= state_d;
    end
  end

  // descriptor payload
  always_ff @(posedge clk_i) begin
    if (load_desc) begin
      desc_q <= req_desc_i;
    end
  end

endmodule

// ==== hm_lock_table.sv ====
// one lock bit per cache line, indexed by set and way
// unlock is a plain strobe with no grant
// a set and a clear of the same bit in one cycle leave it set
`timescale 1ns/100ps

module hm_lock_table #(
  parameter int unsigned IndexWidth = hm_cfg_pkg::IndexWidth,
  parameter int unsigned Ways       = hm_cfg_pkg::Ways
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  hm_lock_if.tbl                lock,
  input  logic                  unlock_valid_i,
  input  logic [IndexWidth-1:0] unlock_index_i,
  input  logic [Ways-1:0]       unlock_way_i
);

  localparam int unsigned Sets = 2 ** IndexWidth;

  logic [Sets-1:0][Ways-1:0] lock_q;
  logic [Sets-1:0][Ways-1:0] lock_d;

  // query for the line of the held descriptor
  assign lock.locked = |(lock_q[lock.lock_index] & lock.lock_way);

  always_comb begin
    lock_d = lock_q;
    if (unlock_valid_i) begin
      lock_d[unlock_index_i] = lock_d[unlock_index_i] & ~unlock_way_i;
    end
    // set applied last so it wins a collision
    if (lock.lock_set) begin
      lock_d[lock.lock_index] = lock_d[lock.lock_index] | lock.lock_way;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lock_q <= '0;
    end else begin
      lock_q <= lock_d;
    end
  end

endmodule

// ==== hm_tag_store.sv ====
// set-associative tag store with valid, dirty and round-robin victim per set
// lookup and update happen in the cycle of the request transfer
// result is registered and held until acknowledged
// contents are undefined until the init sweep has cleared every index
`timescale 1ns/100ps

module hm_tag_store #(
  parameter int unsigned IndexWidth = hm_cfg_pkg::IndexWidth,
  parameter int unsigned Ways       = hm_cfg_pkg::Ways,
  parameter int unsigned TagWidth   = hm_cfg_pkg::TagWidth
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  clear_valid_i,
  input  logic [IndexWidth-1:0] clear_index_i,
  hm_lookup_if.store            lookup
);

  localparam int unsigned Sets     = 2 ** IndexWidth;
  localparam int unsigned PtrWidth = (Ways > 1) ? $clog2(Ways) : 1;

  // storage arrays
  logic [TagWidth-1:0]   tag_q   [Sets][Ways];
  logic [Ways-1:0]       valid_q [Sets];
  logic [Ways-1:0]       dirty_q [Sets];
  logic [PtrWidth-1:0]   ptr_q   [Sets];

  // lookup signals
  logic [IndexWidth-1:0] idx;
  logic                  req_fire;
  logic [Ways-1:0]       hit_vec;
  logic                  hit;
  logic [PtrWidth-1:0]   victim_idx;
  logic [Ways-1:0]       victim_vec;
  logic                  use_ptr;
  logic [PtrWidth-1:0]   ptr_next;
  logic                  evict;
  logic [TagWidth-1:0]   evict_tag;

  // held result
  logic                  res_valid_q;
  logic                  res_hit_q;
  logic [Ways-1:0]       res_way_q;
  logic                  res_evict_q;
  logic [TagWidth-1:0]   res_evict_tag_q;

  assign idx      = lookup.req_index;
  assign req_fire = lookup.req_valid & lookup.req_ready;

  ////////////////////////////////////////////////////////////////////////////
  // tag compare and victim selection
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    hit_vec    = '0;
    victim_idx = ptr_q[idx];
    use_ptr    = 1'b1;
    // downward scan so the lowest invalid way wins
    for (int w = Ways - 1; w >= 0; w--) begin
      hit_vec[w] = valid_q[idx][w] && (tag_q[idx][w] == lookup.req_tag);
      if (!valid_q[idx][w]) begin
        victim_idx = PtrWidth'(w);
        use_ptr    = 1'b0;
      end
    end
    hit                    = |hit_vec;
    victim_vec             = '0;
    victim_vec[victim_idx] = 1'b1;
    // write back only a valid dirty victim on a miss
    evict     = ~hit & valid_q[idx][victim_idx] & dirty_q[idx][victim_idx];
    evict_tag = evict ? tag_q[idx][victim_idx] : '0;
    // pointer wraps at the last way, also for non power of two
    ptr_next  = (ptr_q[idx] == PtrWidth'(Ways - 1)) ? '0 : ptr_q[idx] + 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // array update
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (clear_valid_i) begin
      // init sweep, one whole set per cycle
      valid_q[clear_index_i] <= '0;
      dirty_q[clear_index_i] <= '0;
      ptr_q[clear_index_i]   <= '0;
    end else if (req_fire) begin
      if (hit) begin
        // a write makes the hit line dirty, a read leaves it
        dirty_q[idx] <= dirty_q[idx] | (hit_vec & {Ways{lookup.req_dirty}});
      end else begin
        tag_q[idx][victim_idx]   <= lookup.req_tag;
        valid_q[idx][victim_idx] <= 1'b1;
        dirty_q[idx][victim_idx] <= lookup.req_dirty;
        // pointer only moves when a valid line was replaced
        if (use_ptr) begin
          ptr_q[idx] <= ptr_next;
        end
      end
    end
  end

  // result handshake
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      res_valid_q <= 1'b0;
    end else if (req_fire) begin
      res_valid_q <= 1'b1;
    end else if (lookup.res_ack) begin
      res_valid_q <= 1'b0;
    end
  end

  // result payload
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      res_hit_q       <= hit;
      res_way_q       <= hit ? hit_vec : victim_vec;
      res_evict_q     <= evict;
      res_evict_tag_q <= evict_tag;
    end
  end

  // a new lookup may overlap the hand-off of the held one
  assign lookup.req_ready     = ~res_valid_q | lookup.res_ack;
  assign lookup.res_valid     = res_valid_q;
  assign lookup.res_hit       = res_hit_q;
  assign lookup.res_way       = res_way_q;
  assign lookup.res_evict     = res_evict_q;
  assign lookup.res_evict_tag = res_evict_tag_q;

endmodule

// ==== hm_init_counter.sv ====
// walks all indices once after reset to clear the tag store
// done_o is already high during the last clear cycle and stays high
// the sweep takes 2^IndexWidth cycles
`timescale 1ns/100ps

module hm_init_counter (
  input  logic                 clk_i,
  input  logic                 rst_i,
  output logic                 clear_valid_o,
  output hm_types_pkg::index_t clear_index_o,
  output logic                 done_o
);
  import hm_types_pkg::*;

  index_t cnt_q;
  logic   done_q;
  logic   last;

  // all ones means the final index is being cleared
  assign last          = (cnt_q == '1);
  assign clear_valid_o = ~done_q;
  assign clear_index_o = cnt_q;
  assign done_o        = done_q | last;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else if (!done_q) begin
      // counter wraps to zero after the last index, done_q keeps it stopped
      cnt_q <= cnt_q + 1'b1;
      if (last) begin
        done_q <= 1'b1;
      end
    end
  end

endmodule

// ==== hm_lock_if.sv ====
// lock query and set between controller and lock table
// locked answers combinationally for lock_index and lock_way
`timescale 1ns/100ps

interface hm_lock_if #(
  parameter int unsigned IndexWidth = hm_cfg_pkg::IndexWidth,
  parameter int unsigned Ways       = hm_cfg_pkg::Ways
) ();

  // one-cycle pulse, bit is set at the next edge
  logic                  lock_set;
  logic [IndexWidth-1:0] lock_index;
  // one-hot way of the line
  logic [Ways-1:0]       lock_way;
  logic                  locked;

  modport ctrl (output lock_set, lock_index, lock_way, input locked);

  modport tbl (input lock_set, lock_index, lock_way, output locked);

endinterface

// ==== hm_lookup_if.sv ====
// request/result channel between controller and tag store
// req transfers on req_valid and req_ready, result follows one cycle later
// result is held until res_ack
`timescale 1ns/100ps

interface hm_lookup_if #(
  parameter int unsigned IndexWidth = hm_cfg_pkg::IndexWidth,
  parameter int unsigned Ways       = hm_cfg_pkg::Ways,
  parameter int unsigned TagWidth   = hm_cfg_pkg::TagWidth
) ();

  // request side
  logic                  req_valid;
  logic                  req_ready;
  logic [IndexWidth-1:0] req_index;
  logic [TagWidth-1:0]   req_tag;
  // a write marks the line dirty
  logic                  req_dirty;

  // result side
  logic                  res_valid;
  logic                  res_ack;
  logic                  res_hit;
  logic [Ways-1:0]       res_way;
  logic                  res_evict;
  logic [TagWidth-1:0]   res_evict_tag;

  modport ctrl (
    output req_valid, req_index, req_tag, req_dirty, res_ack,
    input  req_ready, res_valid, res_hit, res_way, res_evict, res_evict_tag
  );

  modport store (
    input  req_valid, req_index, req_tag, req_dirty, res_ack,
    output req_ready, res_valid, res_hit, res_way, res_evict, res_evict_tag
  );

endinterface

// ==== hm_types_pkg.sv ====
// descriptor and tag types of the hit/miss stage
// all widths follow the hm_cfg_pkg defaults
// out_desc_t carries the request unchanged plus the lookup result
package hm_types_pkg;
  import hm_cfg_pkg::*;

  // one-hot way selector
  typedef logic [Ways-1:0]       way_ind_t;
  typedef logic [IndexWidth-1:0] index_t;
  typedef logic [TagWidth-1:0]   tag_t;

  // incoming request, rw high means write
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 rw;
    logic [IdWidth-1:0]   id;
  } req_desc_t;

  // outgoing descriptor after the lookup
  typedef struct packed {
    // original request
    req_desc_t req;
    // way to operate on, hit way or victim
    way_ind_t  way_ind;
    // line has to be fetched from memory
    logic      refill;
    // victim was dirty and must be written back
    logic      evict;
    // tag of the written back line
    tag_t      evict_tag;
  } out_desc_t;

endpackage

// ==== hm_cfg_pkg.sv ====
// cache geometry for the hit/miss stage
// defaults only, the top level passes IndexWidth, Ways and TagWidth down
// address layout is {tag, index, offset}, offset covers byte and block bits
// Ways above 1 is expected by the round-robin replacement
package hm_cfg_pkg;

  // number of index bits, one set per index
  parameter int unsigned IndexWidth  = 4;
  // associativity
  parameter int unsigned Ways        = 2;
  // stored tag bits per line
  parameter int unsigned TagWidth    = 8;
  // byte plus block offset bits
  parameter int unsigned OffsetWidth = 4;
  // request id width
  parameter int unsigned IdWidth     = 4;

  // derived widths and field positions in the address
  parameter int unsigned AddrWidth   = OffsetWidth + IndexWidth + TagWidth;
  parameter int unsigned IndexBase   = OffsetWidth;
  parameter int unsigned TagBase     = OffsetWidth + IndexWidth;

endpackage
